/* rtl/axpy_mem_pkg.sv */
//////////////////////////////
// Vector memory geometry shared by the x and y memories,
// the engine and the top level
//////////////////////////////

package axpy_mem_pkg;

  // Width of one vector element
  localparam int DATA_WIDTH = 32;

  // Elements held in each memory
  localparam int VEC_SIZE = 16;

  // Index width, enough for VEC_SIZE entries
  localparam int IDX_WIDTH = 4;

endpackage

/* rtl/axpy_ctrl_pkg.sv */
//////////////////////////////
// Control encodings for the axpy accelerator: engine states,
// host register map and memory select values
//////////////////////////////

package axpy_ctrl_pkg;

  // Engine FSM states
  typedef enum logic [1:0] {
    IDLE,
    READ,
    WRITE,
    FINISH
  } engine_state_e;

  // Host register addresses
  typedef enum logic [1:0] {
    REG_CTRL,
    REG_SCALAR,
    REG_LAST_IDX,
    REG_STATUS
  } reg_addr_e;

  // Target of a host memory access
  typedef enum logic {
    MEM_X,
    MEM_Y
  } mem_sel_e;

  // Bit positions inside REG_CTRL and REG_STATUS
  localparam int CTRL_START_BIT  = 0;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

/* rtl/seq_mem_d1.sv */
//////////////////////////////
// Flat sequential memory, one-cycle registered read and write,
// each acknowledged by a done pulse the cycle after its enable
//////////////////////////////

`timescale 1ns/10ps

module seq_mem_d1 (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  addr0,

  input  logic                                read_en,
  output logic [axpy_mem_pkg::DATA_WIDTH-1:0] read_data,
  output logic                                read_done,

  input  logic [axpy_mem_pkg::DATA_WIDTH-1:0] write_data,
  input  logic                                write_en,
  output logic                                write_done
);

  // Storage array
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] mem [axpy_mem_pkg::VEC_SIZE];

  // Registered read output
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] read_q;

  assign read_data = read_q;

  // Read port, output goes undefined once a write is issued
  always_ff @(posedge clk) begin
    if (read_en) begin
      read_q <= mem[addr0];
    end else if (write_en) begin
      read_q <= 'x;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[addr0] <= write_data;
    end
  end

  // Completion pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      read_done <= 1'b0;
    end else begin
      read_done <= read_en;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      write_done <= 1'b0;
    end else begin
      write_done <= write_en;
    end
  end

  // Only one access per cycle
  a_single_access: assert property (
    @(posedge clk) disable iff (reset)
    !(read_en && write_en)
  ) else $error("seq_mem_d1: read and write requested together");

endmodule

/* rtl/axpy_cfg_regs.sv */
//////////////////////////////
// Host register block for the axpy engine: scalar, last index,
// start command and sticky done status
//////////////////////////////

`timescale 1ns/10ps

module axpy_cfg_regs (
  input  logic                                clk,
  input  logic                                reset,

  // Host register port
  input  logic                                reg_wr_en,
  input  axpy_ctrl_pkg::reg_addr_e            reg_addr,
  input  logic [axpy_mem_pkg::DATA_WIDTH-1:0] reg_wr_data,
  output logic [axpy_mem_pkg::DATA_WIDTH-1:0] reg_rd_data,

  // Engine side
  input  logic                                busy,
  input  logic                                done,
  output logic                                start,
  output logic [axpy_mem_pkg::DATA_WIDTH-1:0] scalar,
  output logic [axpy_mem_pkg::IDX_WIDTH-1:0]  last_idx
);

  logic [axpy_mem_pkg::DATA_WIDTH-1:0] scalar_q;
  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  last_idx_q;
  logic                                done_q;

  assign scalar   = scalar_q;
  assign last_idx = last_idx_q;

  // Start request is dropped while the engine runs
  assign start = reg_wr_en && (reg_addr == axpy_ctrl_pkg::REG_CTRL) &&
                 reg_wr_data[axpy_ctrl_pkg::CTRL_START_BIT] && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      scalar_q   <= '0;
      last_idx_q <= '0;
    end else if (reg_wr_en) begin
      if (reg_addr == axpy_ctrl_pkg::REG_SCALAR) begin
        scalar_q <= reg_wr_data;
      end
      if (reg_addr == axpy_ctrl_pkg::REG_LAST_IDX) begin
        last_idx_q <= reg_wr_data[axpy_mem_pkg::IDX_WIDTH-1:0];
      end
    end
  end

  // Sticky done, set by the engine and cleared by the next start
  always_ff @(posedge clk) begin
    if (reset) begin
      done_q <= 1'b0;
    end else if (done) begin
      done_q <= 1'b1;
    end else if (start) begin
      done_q <= 1'b0;
    end
  end

  // Readback mux
  always_comb begin
    reg_rd_data = '0;
    case (reg_addr)
      axpy_ctrl_pkg::REG_SCALAR: begin
        reg_rd_data = scalar_q;
      end
      axpy_ctrl_pkg::REG_LAST_IDX: begin
        reg_rd_data[axpy_mem_pkg::IDX_WIDTH-1:0] = last_idx_q;
      end
      axpy_ctrl_pkg::REG_STATUS: begin
        reg_rd_data[axpy_ctrl_pkg::STATUS_BUSY_BIT] = busy;
        reg_rd_data[axpy_ctrl_pkg::STATUS_DONE_BIT] = done_q;
      end
      default: begin
        // REG_CTRL reads back as zero
        reg_rd_data = '0;
      end
    endcase
  end

  // An accepted start must put the engine into its busy states
  a_start_taken: assert property (
    @(posedge clk) disable iff (reset)
    start |=> busy
  ) else $error("axpy_cfg_regs: start not taken up by an idle engine");

endmodule

/* rtl/axpy_engine.sv */
//////////////////////////////
// axpy engine FSM, computes y[i] = a*x[i] + y[i] over both memories
// and hands the memory ports to the host while idle
//////////////////////////////

`timescale 1ns/10ps

module axpy_engine (
  input  logic                                clk,
  input  logic                                reset,

  // Register block side
  input  logic                                start,
  input  logic [axpy_mem_pkg::DATA_WIDTH-1:0] scalar,
  input  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  last_idx,
  output logic                                busy,
  output logic                                done,

  // Host memory port
  input  axpy_ctrl_pkg::mem_sel_e             host_mem_sel,
  input  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  host_addr,
  input  logic                                host_rd_en,
  input  logic                                host_wr_en,
  input  logic [axpy_mem_pkg::DATA_WIDTH-1:0] host_wr_data,
  output logic [axpy_mem_pkg::DATA_WIDTH-1:0] host_rd_data,
  output logic                                host_rd_done,

  // x memory
  output logic [axpy_mem_pkg::IDX_WIDTH-1:0]  x_addr,
  output logic                                x_rd_en,
  output logic                                x_wr_en,
  output logic [axpy_mem_pkg::DATA_WIDTH-1:0] x_wr_data,
  input  logic [axpy_mem_pkg::DATA_WIDTH-1:0] x_rd_data,
  input  logic                                x_rd_done,

  // y memory
  output logic [axpy_mem_pkg::IDX_WIDTH-1:0]  y_addr,
  output logic                                y_rd_en,
  output logic                                y_wr_en,
  output logic [axpy_mem_pkg::DATA_WIDTH-1:0] y_wr_data,
  input  logic [axpy_mem_pkg::DATA_WIDTH-1:0] y_rd_data,
  input  logic                                y_rd_done,
  input  logic                                y_wr_done
);

  axpy_ctrl_pkg::engine_state_e        state_q;
  axpy_ctrl_pkg::engine_state_e        state_d;
  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  idx_q;
  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  idx_d;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] mac_result;
  axpy_ctrl_pkg::mem_sel_e             host_sel_q;
  logic                                host_rd_q;
  logic                                idle;
  logic                                host_x;
  logic                                host_y;
  logic                                operands_ready;

  assign idle = (state_q == axpy_ctrl_pkg::IDLE);
  assign busy = !idle;

  // Completion pulse waits for the final y write to land
  assign done = (state_q == axpy_ctrl_pkg::FINISH) && y_wr_done;

  assign host_x = idle && (host_mem_sel == axpy_ctrl_pkg::MEM_X);
  assign host_y = idle && (host_mem_sel == axpy_ctrl_pkg::MEM_Y);

  assign operands_ready = x_rd_done && y_rd_done;

  // Truncated to the data width
  assign mac_result = scalar * x_rd_data + y_rd_data;

  // x is only ever read by the engine
  assign x_addr    = idle ? host_addr : idx_q;
  assign x_rd_en   = idle ? (host_x && host_rd_en) : (state_q == axpy_ctrl_pkg::READ);
  assign x_wr_en   = host_x && host_wr_en;
  assign x_wr_data = host_wr_data;

  assign y_addr    = idle ? host_addr : idx_q;
  assign y_rd_en   = idle ? (host_y && host_rd_en) : (state_q == axpy_ctrl_pkg::READ);
  assign y_wr_en   = idle ? (host_y && host_wr_en)
                          : ((state_q == axpy_ctrl_pkg::WRITE) && operands_ready);
  assign y_wr_data = idle ? host_wr_data : mac_result;

  // Next state and index
  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    case (state_q)
      axpy_ctrl_pkg::IDLE: begin
        if (start) begin
          state_d = axpy_ctrl_pkg::READ;
          idx_d   = '0;
        end
      end
      axpy_ctrl_pkg::READ: begin
        state_d = axpy_ctrl_pkg::WRITE;
      end
      axpy_ctrl_pkg::WRITE: begin
        if (operands_ready) begin
          if (idx_q == last_idx) begin
            state_d = axpy_ctrl_pkg::FINISH;
          end else begin
            state_d = axpy_ctrl_pkg::READ;
            idx_d   = idx_q + 1'b1;
          end
        end
      end
      axpy_ctrl_pkg::FINISH: begin
        if (y_wr_done) begin
          state_d = axpy_ctrl_pkg::IDLE;
        end
      end
      default: begin
        state_d = axpy_ctrl_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= axpy_ctrl_pkg::IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  // Remember which memory the last accepted host read went to
  always_ff @(posedge clk) begin
    if (reset) begin
      host_sel_q <= axpy_ctrl_pkg::MEM_X;
      host_rd_q  <= 1'b0;
    end else begin
      host_rd_q <= idle && host_rd_en;
      if (idle && host_rd_en) begin
        host_sel_q <= host_mem_sel;
      end
    end
  end

  assign host_rd_data = (host_sel_q == axpy_ctrl_pkg::MEM_X) ? x_rd_data : y_rd_data;

  // Engine reads never show up as host read completions
  assign host_rd_done = host_rd_q &&
                        ((host_sel_q == axpy_ctrl_pkg::MEM_X) ? x_rd_done : y_rd_done);

  // Both memories answer an engine read in the following cycle
  a_operands_ready: assert property (
    @(posedge clk) disable iff (reset)
    (state_q == axpy_ctrl_pkg::WRITE) |-> operands_ready
  ) else $error("axpy_engine: read data missing in WRITE");

endmodule

/* rtl/axpy_top.sv */
//////////////////////////////
// axpy accelerator top: register block, engine, x and y memories
//////////////////////////////

`timescale 1ns/10ps

module axpy_top (
  input  logic                                clk,
  input  logic                                reset,

  // Host register port
  input  logic                                reg_wr_en,
  input  axpy_ctrl_pkg::reg_addr_e            reg_addr,
  input  logic [axpy_mem_pkg::DATA_WIDTH-1:0] reg_wr_data,
  output logic [axpy_mem_pkg::DATA_WIDTH-1:0] reg_rd_data,

  // Host memory port
  input  axpy_ctrl_pkg::mem_sel_e             host_mem_sel,
  input  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  host_addr,
  input  logic                                host_rd_en,
  input  logic                                host_wr_en,
  input  logic [axpy_mem_pkg::DATA_WIDTH-1:0] host_wr_data,
  output logic [axpy_mem_pkg::DATA_WIDTH-1:0] host_rd_data,
  output logic                                host_rd_done
);

  // Register block to engine
  logic                                start;
  logic                                busy;
  logic                                done;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] scalar;
  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  last_idx;

  // Engine to memories
  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  x_addr;
  logic                                x_rd_en;
  logic                                x_wr_en;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] x_wr_data;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] x_rd_data;
  logic                                x_rd_done;
  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  y_addr;
  logic                                y_rd_en;
  logic                                y_wr_en;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] y_wr_data;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] y_rd_data;
  logic                                y_rd_done;
  logic                                y_wr_done;

  axpy_cfg_regs i_cfg_regs (
    .clk         (clk),
    .reset       (reset),
    .reg_wr_en   (reg_wr_en),
    .reg_addr    (reg_addr),
    .reg_wr_data (reg_wr_data),
    .reg_rd_data (reg_rd_data),
    .busy        (busy),
    .done        (done),
    .start       (start),
    .scalar      (scalar),
    .last_idx    (last_idx)
  );

  axpy_engine i_engine (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .scalar       (scalar),
    .last_idx     (last_idx),
    .busy         (busy),
    .done         (done),
    .host_mem_sel (host_mem_sel),
    .host_addr    (host_addr),
    .host_rd_en   (host_rd_en),
    .host_wr_en   (host_wr_en),
    .host_wr_data (host_wr_data),
    .host_rd_data (host_rd_data),
    .host_rd_done (host_rd_done),
    .x_addr       (x_addr),
    .x_rd_en      (x_rd_en),
    .x_wr_en      (x_wr_en),
    .x_wr_data    (x_wr_data),
    .x_rd_data    (x_rd_data),
    .x_rd_done    (x_rd_done),
    .y_addr       (y_addr),
    .y_rd_en      (y_rd_en),
    .y_wr_en      (y_wr_en),
    .y_wr_data    (y_wr_data),
    .y_rd_data    (y_rd_data),
    .y_rd_done    (y_rd_done),
    .y_wr_done    (y_wr_done)
  );

  // Only the host writes x, so its write completion goes nowhere
  seq_mem_d1 i_x_mem (
    .clk        (clk),
    .reset      (reset),
    .addr0      (x_addr),
    .read_en    (x_rd_en),
    .read_data  (x_rd_data),
    .read_done  (x_rd_done),
    .write_data (x_wr_data),
    .write_en   (x_wr_en),
    .write_done ()
  );

  seq_mem_d1 i_y_mem (
    .clk        (clk),
    .reset      (reset),
    .addr0      (y_addr),
    .read_en    (y_rd_en),
    .read_data  (y_rd_data),
    .read_done  (y_rd_done),
    .write_data (y_wr_data),
    .write_en   (y_wr_en),
    .write_done (y_wr_done)
  );

endmodule

/* dv/axpy_tb.sv */
//////////////////////////////
// Directed testbench for the axpy accelerator top level.
// Loads x and y, runs the engine and checks y against a model
//////////////////////////////

`timescale 1ns/10ps

module axpy_tb;

  logic                                clk;
  logic                                reset;
  logic                                reg_wr_en;
  axpy_ctrl_pkg::reg_addr_e            reg_addr;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] reg_wr_data;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] reg_rd_data;
  axpy_ctrl_pkg::mem_sel_e             host_mem_sel;
  logic [axpy_mem_pkg::IDX_WIDTH-1:0]  host_addr;
  logic                                host_rd_en;
  logic                                host_wr_en;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] host_wr_data;
  logic [axpy_mem_pkg::DATA_WIDTH-1:0] host_rd_data;
  logic                                host_rd_done;

  // Model copies of both vectors
  logic [31:0] x_model [axpy_mem_pkg::VEC_SIZE];
  logic [31:0] y_model [axpy_mem_pkg::VEC_SIZE];
  logic [31:0] lcg_state;
  int          errors;
  int          test_start_errors;
  int          tests_run;
  int          tests_failed;
  bit          aborted;

  axpy_top i_dut (
    .clk          (clk),
    .reset        (reset),
    .reg_wr_en    (reg_wr_en),
    .reg_addr     (reg_addr),
    .reg_wr_data  (reg_wr_data),
    .reg_rd_data  (reg_rd_data),
    .host_mem_sel (host_mem_sel),
    .host_addr    (host_addr),
    .host_rd_en   (host_rd_en),
    .host_wr_en   (host_wr_en),
    .host_wr_data (host_wr_data),
    .host_rd_data (host_rd_data),
    .host_rd_done (host_rd_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // Inputs change 1 ns after each rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic begin_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors > test_start_errors) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - test_start_errors);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic reg_write(input axpy_ctrl_pkg::reg_addr_e addr, input logic [31:0] data);
    reg_wr_en   = 1'b1;
    reg_addr    = addr;
    reg_wr_data = data;
    tick();
    reg_wr_en   = 1'b0;
  endtask

  task automatic reg_read(input axpy_ctrl_pkg::reg_addr_e addr, output logic [31:0] data);
    reg_addr = addr;
    #1;
    data = reg_rd_data;
    tick();
  endtask

  task automatic host_write(input axpy_ctrl_pkg::mem_sel_e sel, input int idx,
                            input logic [31:0] data);
    host_mem_sel = sel;
    host_addr    = idx;
    host_wr_data = data;
    host_wr_en   = 1'b1;
    tick();
    host_wr_en   = 1'b0;
  endtask

  // Data and done are both due one cycle after the enable
  task automatic host_read(input axpy_ctrl_pkg::mem_sel_e sel, input int idx,
                           output logic [31:0] data, output logic done);
    host_mem_sel = sel;
    host_addr    = idx;
    host_rd_en   = 1'b1;
    tick();
    host_rd_en   = 1'b0;
    data = host_rd_data;
    done = host_rd_done;
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int          cycles;
    cycles = 0;
    status = '0;
    while (!status[axpy_ctrl_pkg::STATUS_DONE_BIT] && cycles < 200) begin
      reg_read(axpy_ctrl_pkg::REG_STATUS, status);
      cycles++;
    end
    if (!status[axpy_ctrl_pkg::STATUS_DONE_BIT]) begin
      $display("Timed out after 200 cycles waiting for the engine to report done");
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic load_vectors();
    for (int i = 0; i < axpy_mem_pkg::VEC_SIZE; i++) begin
      x_model[i] = lcg_next();
      y_model[i] = lcg_next();
      host_write(axpy_ctrl_pkg::MEM_X, i, x_model[i]);
      host_write(axpy_ctrl_pkg::MEM_Y, i, y_model[i]);
    end
  endtask

  task automatic check_vectors();
    logic [31:0] data;
    logic        done;
    for (int i = 0; i < axpy_mem_pkg::VEC_SIZE; i++) begin
      host_read(axpy_ctrl_pkg::MEM_X, i, data, done);
      check_value("host_rd_done", {31'b0, done}, 32'h1);
      check_value($sformatf("x[%0d]", i), data, x_model[i]);
      host_read(axpy_ctrl_pkg::MEM_Y, i, data, done);
      check_value("host_rd_done", {31'b0, done}, 32'h1);
      check_value($sformatf("y[%0d]", i), data, y_model[i]);
    end
  endtask

  // y = a*x + y, kept to 32 bits
  task automatic apply_model(input logic [31:0] a, input int last);
    for (int i = 0; i <= last; i++) begin
      y_model[i] = a * x_model[i] + y_model[i];
    end
  endtask

  task automatic run_engine(input logic [31:0] a, input int last);
    logic [31:0] status;
    reg_write(axpy_ctrl_pkg::REG_SCALAR, a);
    reg_write(axpy_ctrl_pkg::REG_LAST_IDX, last);
    reg_write(axpy_ctrl_pkg::REG_CTRL, 32'h1);
    reg_read(axpy_ctrl_pkg::REG_STATUS, status);
    check_value("status", status, 32'h1);
    apply_model(a, last);
  endtask

  task automatic test_reset_values();
    logic [31:0] data;
    begin_test();
    reg_read(axpy_ctrl_pkg::REG_STATUS, data);
    check_value("status", data, 32'h0);
    reg_read(axpy_ctrl_pkg::REG_SCALAR, data);
    check_value("scalar", data, 32'h0);
    reg_read(axpy_ctrl_pkg::REG_LAST_IDX, data);
    check_value("last_idx", data, 32'h0);
    check_value("host_rd_done", {31'b0, host_rd_done}, 32'h0);
    end_test("reset values");
  endtask

  task automatic test_host_access();
    begin_test();
    load_vectors();
    check_vectors();
    end_test("host access");
  endtask

  task automatic test_full_run();
    begin_test();
    run_engine(lcg_next(), 15);
    wait_done();
    check_vectors();
    end_test("full run");
  endtask

  task automatic test_partial_run();
    begin_test();
    load_vectors();
    run_engine(lcg_next(), 5);
    wait_done();
    check_vectors();
    end_test("partial run");
  endtask

  task automatic test_busy_ignores();
    logic [31:0] status;
    begin_test();
    run_engine(lcg_next(), 15);
    reg_write(axpy_ctrl_pkg::REG_CTRL, 32'h1);
    host_write(axpy_ctrl_pkg::MEM_Y, 3, 32'hdead_beef);
    host_mem_sel = axpy_ctrl_pkg::MEM_X;
    host_addr    = 0;
    host_rd_en   = 1'b1;
    tick();
    host_rd_en   = 1'b0;
    check_value("host_rd_done", {31'b0, host_rd_done}, 32'h0);
    wait_done();
    reg_read(axpy_ctrl_pkg::REG_STATUS, status);
    check_value("status", status, 32'h2);
    check_vectors();
    end_test("busy ignores start and host access");
  endtask

  task automatic test_restart_status();
    logic [31:0] data;
    logic [31:0] a;
    begin_test();
    a = lcg_next();
    run_engine(a, 9);
    reg_read(axpy_ctrl_pkg::REG_SCALAR, data);
    check_value("scalar", data, a);
    reg_read(axpy_ctrl_pkg::REG_LAST_IDX, data);
    check_value("last_idx", data, 32'h9);
    wait_done();
    check_vectors();
    end_test("restart clears done");
  endtask

  initial begin
    reset        = 1'b1;
    reg_wr_en    = 1'b0;
    reg_addr     = axpy_ctrl_pkg::REG_CTRL;
    reg_wr_data  = '0;
    host_mem_sel = axpy_ctrl_pkg::MEM_X;
    host_addr    = '0;
    host_rd_en   = 1'b0;
    host_wr_en   = 1'b0;
    host_wr_data = '0;
    lcg_state    = 32'd26;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset_values();
    test_host_access();
    if (!aborted) test_full_run();
    if (!aborted) test_partial_run();
    if (!aborted) test_busy_ignores();
    if (!aborted) test_restart_status();

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/axpy_mem_pkg.sv
rtl/axpy_ctrl_pkg.sv
rtl/seq_mem_d1.sv
rtl/axpy_cfg_regs.sv
rtl/axpy_engine.sv
rtl/axpy_top.sv
dv/axpy_tb.sv
